// File: all.f
verilog/ptwPkg.sv
verilog/walkRequestIf.sv
verilog/missArbiter.sv
verilog/pteChecker.sv
verilog/walkerFsm.sv
verilog/pageTableWalker.sv
tests/walkerFsm_properties.sv
tests/tbPageTableWalker.sv

// File: Makefile
# Verilator flow for the Sv32 page table walker

VERILATOR ?= verilator
TOP       ?= tbPageTableWalker
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, pass only when the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// File: tests/walkInput.dat
// Memory image: pair count, then word address (byte address / 4) and entry value
// Requests: count, then kind (0 instr, 1 data, 2 both) store vaddr satp outcome entry pageType
// Outcome codes: 0 no walk, 1 itlbWrite, 2 dtlbWrite, 3 instrFault, 4 loadFault, 5 storeFault
00000009
// Root table at PPN 0x100
00040001 00040401
00040002 0AB000C7
00040003 0AB0044B
00040005 00040801
00040006 000000C5
// Second level table at PPN 0x101
00040401 08D1584B
// Second level table at PPN 0x102
00040800 048D1487
00040801 048D1447
00040802 048D14C7
// Requests
0000000C
// Two level instruction walk to a kilopage
0 0 00401000 80000100 1 08D1584B 0
// Aligned megapage on a load
1 0 00800000 80000100 2 0AB000C7 1
// Misaligned megapage, instruction then load
0 0 00C00000 80000100 3 00000000 0
1 0 00C00000 80000100 4 00000000 0
// Invalid root entry
0 0 01000000 80000100 3 00000000 0
// Accessed clear, dirty clear, good store
1 0 01400000 80000100 4 00000000 0
1 1 01401000 80000100 5 00000000 0
1 1 01402000 80000100 2 048D14C7 0
// Write without read
1 1 01800000 80000100 5 00000000 0
// Both misses together, data record then instruction record
2 0 00800000 80000100 2 0AB000C7 1
0 0 00401000 80000100 1 08D1584B 0
// Bare mode, no walk
0 0 00401000 00000100 0 00000000 0

// File: tests/tbPageTableWalker.sv
// Testbench for the Sv32 page table walker, file driven walks against a memory model
`default_nettype none
`timescale 1ns/1ps

module tbPageTableWalker;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] satp;
  logic [31:0] pc;
  logic [31:0] memAdr;
  logic        itlbMiss;
  logic        dtlbMiss;
  logic        memStore;
  logic [31:0] pteData;
  logic        memStall;
  logic        pteRead;
  logic [33:0] pteAdr;
  logic        itlbWrite;
  logic        dtlbWrite;
  logic [31:0] pageTableEntry;
  logic [1:0]  pageType;
  logic        instrFault;
  logic        loadFault;
  logic        storeFault;
  logic        stall;

  // Raw words of the data file
  logic [31:0] vec [0:255];
  // Sparse page table image
  logic [31:0] memAdrs [$];
  logic [31:0] memVals [$];
  // Addresses of the reads in the current walk
  logic [33:0] readAdrs [$];
  logic [31:0] rngState = 32'h6c4e_638a;
  int          testErrors;
  int          passedTests;
  int          failedTests;
  logic        timedOut;

  pageTableWalker DUT (
    .clk (clk), .rst (rst), .satp (satp), .pc (pc), .memAdr (memAdr),
    .itlbMiss (itlbMiss), .dtlbMiss (dtlbMiss), .memStore (memStore),
    .pteData (pteData), .memStall (memStall), .pteRead (pteRead), .pteAdr (pteAdr),
    .itlbWrite (itlbWrite), .dtlbWrite (dtlbWrite), .pageTableEntry (pageTableEntry),
    .pageType (pageType), .instrFault (instrFault), .loadFault (loadFault),
    .storeFault (storeFault), .stall (stall)
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Missing words read as zero, an invalid entry
  function automatic logic [31:0] lookupWord(input logic [33:0] adr);
    logic [31:0] word;
    int          i;
    word = '0;
    for (i = 0; i < memAdrs.size(); i++) begin
      if (memAdrs[i] == adr[33:2]) word = memVals[i];
    end
    return word;
  endfunction

  // 0 none, 1 itlb, 2 dtlb, 3 instr, 4 load, 5 store, 7 several
  function automatic logic [2:0] endCode();
    logic [4:0] pulses;
    pulses = {storeFault, loadFault, instrFault, dtlbWrite, itlbWrite};
    case (pulses)
      5'b00000: return 3'd0;
      5'b00001: return 3'd1;
      5'b00010: return 3'd2;
      5'b00100: return 3'd3;
      5'b01000: return 3'd4;
      5'b10000: return 3'd5;
      default:  return 3'd7;
    endcase
  endfunction

  task automatic reportMismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("[FAIL] t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
    testErrors++;
  endtask

  task automatic endRun();
    $display("Tests: %0d passed, %0d failed", passedTests, failedTests);
    if (failedTests == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic applyReset();
    @(posedge clk);
    #2;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  task automatic recordTest(input int num, input int base);
    string verdict;
    if (testErrors == 0) begin
      passedTests++;
      verdict = "ok";
    end else begin
      failedTests++;
      verdict = "FAILED";
    end
    $display("Test %0d va %h outcome %0d: %s", num + 1, vec[base+2], vec[base+4], verdict);
  endtask

  // Bare mode, nothing may move for 20 cycles
  task automatic checkNoWalk();
    int cycles;
    cycles = 0;
    while (cycles < 20) begin
      @(negedge clk);
      cycles++;
      if (pteRead || stall || endCode() != 3'd0) begin
        $display("Walk activity at t=%0t although satp selects bare mode", $time);
        testErrors++;
      end
    end
  endtask

  task automatic finishWalk(input int base);
    int          cycles;
    int          expReads;
    logic        done;
    logic        sawRead;
    logic [2:0]  code;
    logic [31:0] va;
    logic [31:0] rootEntry;
    logic [33:0] expAdr1;
    logic [33:0] expAdr0;
    cycles = 0;
    done = 1'b0;
    sawRead = 1'b0;
    code = 3'd0;
    va = vec[base+2];
    while (!done && cycles < 200) begin
      @(negedge clk);
      cycles++;
      if (pteRead) sawRead = 1'b1;
      code = endCode();
      if (code != 3'd0) begin
        done = 1'b1;
      end else if (sawRead && !stall) begin
        $display("stall dropped at t=%0t before the walk ended", $time);
        testErrors++;
      end
    end
    if (!done) begin
      $display("Timeout: no TLB write or fault within 200 cycles of the miss at va %h", va);
      testErrors++;
      timedOut = 1'b1;
    end else begin
      if (code != vec[base+4][2:0]) reportMismatch("outcome", 64'(vec[base+4]), 64'(code));
      if (code == 3'd1 || code == 3'd2) begin
        if (pageTableEntry != vec[base+5]) begin
          reportMismatch("pageTableEntry", 64'(vec[base+5]), 64'(pageTableEntry));
        end
        if (pageType != vec[base+6][1:0]) begin
          reportMismatch("pageType", 64'(vec[base+6]), 64'(pageType));
        end
      end
      // Root PPN, VPN1, entry size, then the pointer PPN with VPN0
      expAdr1 = {satp[21:0], va[31:22], 2'b00};
      rootEntry = lookupWord(expAdr1);
      expAdr0 = {rootEntry[31:10], va[21:12], 2'b00};
      expReads = (rootEntry[0] && rootEntry[3:1] == 3'b000) ? 2 : 1;
      if (readAdrs.size() != expReads) begin
        reportMismatch("pteRead count", 64'(expReads), 64'(readAdrs.size()));
      end else begin
        if (readAdrs[0] != expAdr1) reportMismatch("pteAdr", 64'(expAdr1), 64'(readAdrs[0]));
        if (expReads == 2 && readAdrs[1] != expAdr0) begin
          reportMismatch("pteAdr", 64'(expAdr0), 64'(readAdrs[1]));
        end
      end
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  initial begin
    int holdCycles;
    memStall = 1'b0;
    pteData = '0;
    forever begin
      @(negedge clk);
      if (pteRead) begin
        readAdrs.push_back(pteAdr);
        rngState = xorshift(rngState);
        holdCycles = int'(rngState[1:0]);
        @(posedge clk);
        #2;
        // Junk on the bus while stalled
        repeat (holdCycles) begin
          memStall = 1'b1;
          pteData = rngState;
          @(posedge clk);
          #2;
        end
        memStall = 1'b0;
        pteData = lookupWord(readAdrs[readAdrs.size()-1]);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int numMem;
    int numTests;
    int recBase;
    int base;
    int t;
    int i;
    rst = 1'b1;
    satp = '0;
    pc = '0;
    memAdr = '0;
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    memStore = 1'b0;
    passedTests = 0;
    failedTests = 0;
    testErrors = 0;
    timedOut = 1'b0;
    $readmemh("tests/walkInput.dat", vec);
    numMem = int'(vec[0]);
    for (i = 0; i < numMem; i++) begin
      memAdrs.push_back(vec[1+2*i]);
      memVals.push_back(vec[2+2*i]);
    end
    numTests = int'(vec[1+2*numMem]);
    recBase = 2 + 2 * numMem;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (pteRead || stall || endCode() != 3'd0) begin
      $display("Walker outputs not quiet after reset");
      failedTests++;
    end
    t = 0;
    while (t < numTests && !timedOut) begin
      base = recBase + 7 * t;
      testErrors = 0;
      readAdrs.delete();
      @(posedge clk);
      #2;
      satp = vec[base+3];
      memStore = vec[base+1][0];
      if (vec[base] == 32'd0) begin
        pc = vec[base+2];
        itlbMiss = 1'b1;
      end else begin
        memAdr = vec[base+2];
        dtlbMiss = 1'b1;
      end
      // Instruction half of a pair comes from the next record
      if (vec[base] == 32'd2) begin
        pc = vec[base+9];
        itlbMiss = 1'b1;
      end
      if (vec[base+4] == 32'd0) checkNoWalk();
      else finishWalk(base);
      @(posedge clk);
      #2;
      dtlbMiss = 1'b0;
      memStore = 1'b0;
      recordTest(t, base);
      t++;
      if (vec[base] == 32'd2 && !timedOut) begin
        base = base + 7;
        testErrors = 0;
        readAdrs.delete();
        finishWalk(base);
        recordTest(t, base);
        t++;
        @(posedge clk);
        #2;
      end
      itlbMiss = 1'b0;
      // Bare request is still latched, clear it
      if (vec[base+4] == 32'd0) applyReset();
    end
    endRun();
  end

endmodule

`default_nettype wire

// File: tests/walkerFsm_properties.sv
// Walker FSM assertions on end pulses, address hold and idle stall
`default_nettype none
`timescale 1ns/1ps

module walkerFsm_properties #(
  parameter int paBits = ptwPkg::PA_BITS
) (
  input logic              clk,
  input logic              rst,
  input ptwPkg::walkStateT state,
  input logic              memStall,
  input logic              pteRead,
  input logic [paBits-1:0] pteAdr,
  input logic              itlbWrite,
  input logic              dtlbWrite,
  input logic              instrFault,
  input logic              loadFault,
  input logic              storeFault,
  input logic              stall
);
  import ptwPkg::*;

  logic waitState;
  logic endPulse;

  assign waitState = (state == level1Wait) || (state == level0Wait);
  assign endPulse = itlbWrite | dtlbWrite | instrFault | loadFault | storeFault;

  // One result per cycle at most
  endPulseOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({itlbWrite, dtlbWrite, instrFault, loadFault, storeFault}))
    else $error("more than one TLB write or fault in a cycle");

  // Memory sees the same address through its stall
  adrHeldInStall: assert property (@(posedge clk) disable iff (rst)
    (waitState && memStall) |=> $stable(pteAdr))
    else $error("pteAdr moved while memStall was high");

  // Arbiter has dropped the request by the idle cycle after reset or a walk end
  idleNoStall: assert property (@(posedge clk)
    (rst || endPulse) |=> (!stall && !pteRead))
    else $error("stall or pteRead high in the idle cycle after reset or a walk end");

endmodule

// Attach to every walker instance
bind walkerFsm walkerFsm_properties #(
  .paBits (paBits)
) walkerChecks (
  .clk        (clk),
  .rst        (rst),
  .state      (state),
  .memStall   (memStall),
  .pteRead    (pteRead),
  .pteAdr     (pteAdr),
  .itlbWrite  (itlbWrite),
  .dtlbWrite  (dtlbWrite),
  .instrFault (instrFault),
  .loadFault  (loadFault),
  .storeFault (storeFault),
  .stall      (stall)
);

`default_nettype wire

// File: verilog/pageTableWalker.sv
// Sv32 hardware page table walker top, TLB miss in and TLB write or fault out
`default_nettype none
`timescale 1ns/1ps

module pageTableWalker #(
  parameter int xlen   = ptwPkg::XLEN,
  parameter int paBits = ptwPkg::PA_BITS
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [xlen-1:0]   satp,
  // TLB side
  input  logic [xlen-1:0]   pc,
  input  logic [xlen-1:0]   memAdr,
  input  logic              itlbMiss,
  input  logic              dtlbMiss,
  input  logic              memStore,
  // Memory side
  input  logic [xlen-1:0]   pteData,
  input  logic              memStall,
  output logic              pteRead,
  output logic [paBits-1:0] pteAdr,
  // TLB fill
  output logic              itlbWrite,
  output logic              dtlbWrite,
  output logic [xlen-1:0]   pageTableEntry,
  output logic [1:0]        pageType,
  // Faults and core stall
  output logic              instrFault,
  output logic              loadFault,
  output logic              storeFault,
  output logic              stall
);

  ////////////////////
  // Request path
  ////////////////////

  walkRequestIf walkReq ();

  missArbiter #(
    .xlen (xlen)
  ) arbiter (
    .clk      (clk),
    .rst      (rst),
    .itlbMiss (itlbMiss),
    .dtlbMiss (dtlbMiss),
    .memStore (memStore),
    .pc       (pc),
    .memAdr   (memAdr),
    .req      (walkReq.arbiter)
  );

  ////////////////////
  // Walker
  ////////////////////

  walkerFsm #(
    .xlen   (xlen),
    .paBits (paBits)
  ) walker (
    .clk            (clk),
    .rst            (rst),
    .satp           (satp),
    .req            (walkReq.walker),
    .pteData        (pteData),
    .memStall       (memStall),
    .pteRead        (pteRead),
    .pteAdr         (pteAdr),
    .itlbWrite      (itlbWrite),
    .dtlbWrite      (dtlbWrite),
    .pageTableEntry (pageTableEntry),
    .pageType       (pageType),
    .instrFault     (instrFault),
    .loadFault      (loadFault),
    .storeFault     (storeFault),
    .stall          (stall)
  );

endmodule

`default_nettype wire

// File: verilog/walkerFsm.sv
// Walker FSM, reads both table levels and reports a leaf or a page fault
`default_nettype none
`timescale 1ns/1ps

module walkerFsm #(
  parameter int xlen   = ptwPkg::XLEN,
  parameter int paBits = ptwPkg::PA_BITS
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [xlen-1:0]   satp,
  walkRequestIf.walker      req,
  input  ptwPkg::pteT       pteData,
  input  logic              memStall,
  output logic              pteRead,
  output logic [paBits-1:0] pteAdr,
  output logic              itlbWrite,
  output logic              dtlbWrite,
  output ptwPkg::pteT       pageTableEntry,
  output ptwPkg::pageTypeT  pageType,
  output logic              instrFault,
  output logic              loadFault,
  output logic              storeFault,
  output logic              stall
);
  import ptwPkg::*;

  walkStateT             state;
  walkStateT             nextState;
  pteT                   pteQ;
  pageTypeT              pageTypeQ;
  logic [PPN_BITS-1:0]   rootPpn;
  logic [paBits-1:0]     level1Adr;
  logic [paBits-1:0]     level0Adr;
  logic                  modeSv32;
  logic                  startWalk;
  logic                  waitState;
  logic                  checking;
  logic                  capture;
  logic                  chkLeafOk;
  logic                  chkDescend;
  pageTypeT              chkPageType;

  ////////////////////
  // Address forming
  ////////////////////

  assign rootPpn = satp[PPN_BITS-1:0];
  assign modeSv32 = satp[xlen-1] == SATP_MODE_SV32;

  // PPN, then VPN, then entry size
  assign level1Adr = {rootPpn, req.vpn1, {PTE_BYTES_LOG2{1'b0}}};
  assign level0Adr = {pteQ.ptr.ppn, req.vpn0, {PTE_BYTES_LOG2{1'b0}}};

  // Level 0 address once the root entry is held
  assign pteAdr = (state == level1 || state == level0Wait) ? level0Adr : level1Adr;

  ////////////////////
  // Control decode
  ////////////////////

  assign startWalk = (state == idle) & req.req & modeSv32;
  assign waitState = (state == level1Wait) | (state == level0Wait);
  assign checking = (state == level1) | (state == level0);

  // First cycle with the stall released
  assign capture = waitState & ~memStall;

  pteChecker entryChecker (
    .pte      (pteQ),
    .isStore  (req.isStore),
    .atLevel1 (state == level1),
    .leafOk   (chkLeafOk),
    .descend  (chkDescend),
    .pageType (chkPageType)
  );

  always_comb begin
    nextState = state;
    pteRead = 1'b0;
    case (state)
      idle: begin
        if (startWalk) begin
          nextState = level1Wait;
          pteRead = 1'b1;
        end
      end
      level1Wait: begin
        if (!memStall) begin
          nextState = level1;
        end
      end
      level1: begin
        if (chkLeafOk) begin
          nextState = leaf;
        end else if (chkDescend) begin
          // Pointer, go read level 0
          nextState = level0Wait;
          pteRead = 1'b1;
        end else begin
          nextState = fault;
        end
      end
      level0Wait: begin
        if (!memStall) begin
          nextState = level0;
        end
      end
      level0: begin
        nextState = chkLeafOk ? leaf : fault;
      end
      leaf: nextState = idle;
      fault: nextState = idle;
      default: nextState = idle;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  // Entry as returned by memory
  always_ff @(posedge clk) begin
    if (capture) begin
      pteQ <= pteData;
    end
  end

  // Size of the last checked entry
  always_ff @(posedge clk) begin
    if (checking) begin
      pageTypeQ <= chkPageType;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign pageTableEntry = pteQ;
  assign pageType = pageTypeQ;

  // Route the result to the side that missed
  assign itlbWrite = (state == leaf) & ~req.isData;
  assign dtlbWrite = (state == leaf) & req.isData;
  assign instrFault = (state == fault) & ~req.isData;
  assign loadFault = (state == fault) & req.isData & ~req.isStore;
  assign storeFault = (state == fault) & req.isData & req.isStore;

  // Releases the arbiter
  assign req.walkDone = (state == leaf) | (state == fault);

  // Core held from the first read, dropped on the end pulse
  assign stall = startWalk | waitState | checking;

endmodule

`default_nettype wire

// File: verilog/pteChecker.sv
// Entry checker, classifies a fetched entry as pointer, good leaf or fault
`default_nettype none
`timescale 1ns/1ps

module pteChecker (
  input  ptwPkg::pteT      pte,
  input  logic             isStore,
  input  logic             atLevel1,
  output logic             leafOk,
  output logic             descend,
  output ptwPkg::pageTypeT pageType
);
  import ptwPkg::*;

  pteFlagsT flags;
  logic     isLeaf;
  logic     validPte;
  logic     accessAlert;
  logic     megaMisaligned;

  // Flags sit in the same place in both views
  assign flags = pte.ptr.flags;

  // Any of X, W or R makes it a leaf
  assign isLeaf = flags.executable | flags.writable | flags.readable;

  // Write without read is reserved
  assign validPte = flags.valid & ~(flags.writable & ~flags.readable);

  // Accessed must be set, dirty too on a store
  assign accessAlert = ~flags.accessed | (isStore & ~flags.dirty);

  // Megapage needs a zero ppn0
  assign megaMisaligned = atLevel1 & (|pte.leaf.ppn0);

  ////////////////////
  // Outcome
  ////////////////////

  assign leafOk = validPte & isLeaf & ~accessAlert & ~megaMisaligned;

  // Pointer only allowed at the root level
  assign descend = validPte & ~isLeaf & atLevel1;

  // Leaf size follows the level it was found at
  assign pageType = atLevel1 ? megapage : kilopage;

endmodule

`default_nettype wire

// File: verilog/missArbiter.sv
// Miss arbiter, latches one TLB miss as a walk request with data side priority
`default_nettype none
`timescale 1ns/1ps

module missArbiter #(
  parameter int xlen = ptwPkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            itlbMiss,
  input  logic            dtlbMiss,
  input  logic            memStore,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] memAdr,
  walkRequestIf.arbiter   req
);
  import ptwPkg::*;

  logic            anyMiss;
  logic            takeMiss;
  logic [xlen-1:0] missAdr;

  ////////////////////
  // Selection
  ////////////////////

  assign anyMiss = itlbMiss | dtlbMiss;

  // Only accept while no walk is pending
  assign takeMiss = anyMiss & ~req.req;

  // Data address wins over the program counter
  assign missAdr = dtlbMiss ? memAdr : pc;

  ////////////////////
  // Request register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      req.req <= 1'b0;
      req.isData <= 1'b0;
      req.isStore <= 1'b0;
    end else if (req.walkDone) begin
      // Walker finished, free the slot
      req.req <= 1'b0;
    end else if (takeMiss) begin
      req.req <= 1'b1;
      req.isData <= dtlbMiss;
      // Store flag only means something on the data side
      req.isStore <= dtlbMiss & memStore;
    end
  end

  // VPN fields, stable for the whole walk
  always_ff @(posedge clk) begin
    if (takeMiss) begin
      req.vpn1 <= missAdr[xlen-1 -: VPN_BITS];
      req.vpn0 <= missAdr[PAGE_OFFSET_BITS +: VPN_BITS];
    end
  end

endmodule

`default_nettype wire

// File: verilog/walkRequestIf.sv
// Walk request bundle from the miss arbiter to the walker FSM
`default_nettype none
`timescale 1ns/1ps

interface walkRequestIf;
  import ptwPkg::*;

  // Pending walk, held until walkDone
  logic                req;
  // Virtual page number fields of the latched address
  logic [VPN_BITS-1:0] vpn1;
  logic [VPN_BITS-1:0] vpn0;
  // Data side miss, store access
  logic                isData;
  logic                isStore;
  // One-cycle end of walk pulse
  logic                walkDone;

  modport arbiter (
    output req, vpn1, vpn0, isData, isStore,
    input  walkDone
  );

  modport walker (
    input  req, vpn1, vpn0, isData, isStore,
    output walkDone
  );

endinterface

`default_nettype wire

// File: verilog/ptwPkg.sv
// Sv32 page table walker shared widths, entry layout and state encodings
`default_nettype none

package ptwPkg;

  ////////////////////
  // Sv32 geometry
  ////////////////////

  // Word and physical address widths
  parameter int XLEN = 32;
  parameter int PA_BITS = 34;
  // PPN is 22 bits, split 12 + 10 in a leaf
  parameter int PPN_BITS = 22;
  parameter int VPN_BITS = 10;
  parameter int PAGE_OFFSET_BITS = 12;
  // Four bytes per entry
  parameter int PTE_BYTES_LOG2 = 2;
  // Mode bit in satp[31]
  parameter logic SATP_MODE_SV32 = 1'b1;

  // Leaf size reported to the TLB
  typedef enum logic [1:0] {
    kilopage = 2'd0,
    megapage = 2'd1
  } pageTypeT;

  ////////////////////
  // Entry layout
  ////////////////////

  // Low byte of every entry
  typedef struct packed {
    logic dirty;
    logic accessed;
    logic global;
    logic user;
    logic executable;
    logic writable;
    logic readable;
    logic valid;
  } pteFlagsT;

  // Pointer view, PPN of the next table
  typedef struct packed {
    logic [PPN_BITS-1:0] ppn;
    logic [1:0]          rsw;
    pteFlagsT            flags;
  } ptePointerT;

  // Leaf view, ppn0 must be zero for a megapage
  typedef struct packed {
    logic [PPN_BITS-VPN_BITS-1:0] ppn1;
    logic [VPN_BITS-1:0]          ppn0;
    logic [1:0]                   rsw;
    pteFlagsT                     flags;
  } pteLeafT;

  typedef union packed {
    ptePointerT ptr;
    pteLeafT    leaf;
  } pteT;

  // Walker states
  typedef enum logic [2:0] {
    idle,
    level1Wait,
    level1,
    level0Wait,
    level0,
    leaf,
    fault
  } walkStateT;

endpackage

`default_nettype wire
